// File: common/uart_debug_pkg.sv
package uart_debug_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  // Memory is 2**MEM_ADDR_W bytes deep
  localparam int unsigned MEM_ADDR_W = 8;
  localparam int unsigned LEN_W      = 16;

  // Address bytes, then length bytes, per header
  localparam int unsigned HDR_BYTES  = 8;

  typedef logic [7:0]            byte_t;
  typedef logic [MEM_ADDR_W-1:0] mem_addr_t;
  typedef logic [LEN_W-1:0]      len_t;

  //////////////////////////////
  // Protocol byte codes
  //////////////////////////////

  localparam byte_t CMD_READ  = 8'h11;
  localparam byte_t CMD_WRITE = 8'h12;
  localparam byte_t CODE_ACK  = 8'h06;
  localparam byte_t CODE_EOT  = 8'h04;

  // Parser states
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_ADDR,
    ST_LEN,
    ST_ACK,
    ST_RD_REQ,
    ST_RD_SEND,
    ST_WR_DATA,
    ST_EOT
  } dbg_state_e;

endpackage

// File: common/debug_mem_if.sv
`timescale 1ns/1ps

interface debug_mem_if import uart_debug_pkg::*; ();

  // Request side
  logic      req;
  logic      we;
  mem_addr_t addr;
  byte_t     wdata;

  // Valid the cycle after a read request
  byte_t     rdata;

  modport ctrl (
    output req, we, addr, wdata,
    input  rdata
  );

  modport mem (
    input  req, we, addr, wdata,
    output rdata
  );

endinterface

// File: uart/uart_rx.sv
`timescale 1ns/1ps

module uart_rx import uart_debug_pkg::*; #(
  parameter int unsigned CLKS_PER_BIT = 8
) (
  input  logic  clk,
  input  logic  arst_n_i,
  input  logic  rx_i,
  output logic  rx_valid_o,
  output byte_t rx_data_o
);

  localparam int unsigned      CNT_W     = $clog2(CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CLKS_PER_BIT / 2 - 1);

  logic [1:0]       sync_q;
  logic             line;
  logic             busy_q;
  logic [CNT_W-1:0] baud_q;
  logic [3:0]       bit_q;
  logic             sample;
  logic             valid_q;
  byte_t            shift_q;

  assign line   = sync_q[1];
  // Middle of the current bit
  assign sample = busy_q && (baud_q == '0);

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_q  <= 2'b11;
      busy_q  <= 1'b0;
      baud_q  <= '0;
      bit_q   <= '0;
      valid_q <= 1'b0;
    end else begin
      sync_q  <= {sync_q[0], rx_i};
      valid_q <= 1'b0;
      if (!busy_q) begin
        // Start edge, wait half a bit
        if (!line) begin
          busy_q <= 1'b1;
          baud_q <= HALF_LAST;
          bit_q  <= '0;
        end
      end else if (!sample) begin
        baud_q <= baud_q - 1'b1;
      end else begin
        baud_q <= BIT_LAST;
        bit_q  <= bit_q + 1'b1;
        if (bit_q == 4'd0 && line) begin
          // Glitch, not a real start bit
          busy_q <= 1'b0;
        end else if (bit_q == 4'd9) begin
          // Stop bit must be high
          busy_q  <= 1'b0;
          valid_q <= line;
        end
      end
    end
  end

  // Data bits come in LSB first
  always_ff @(posedge clk) begin
    if (sample && bit_q >= 4'd1 && bit_q <= 4'd8) begin
      shift_q <= {line, shift_q[7:1]};
    end
  end

  assign rx_valid_o = valid_q;
  assign rx_data_o  = shift_q;

endmodule

// File: uart/uart_tx.sv
`timescale 1ns/1ps

module uart_tx import uart_debug_pkg::*; #(
  parameter int unsigned CLKS_PER_BIT = 8
) (
  input  logic  clk,
  input  logic  arst_n_i,
  input  logic  tx_valid_i,
  input  byte_t tx_data_i,
  output logic  tx_ready_o,
  output logic  tx_o
);

  localparam int unsigned      CNT_W    = $clog2(CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);

  logic             busy_q;
  logic [CNT_W-1:0] baud_q;
  logic [3:0]       bit_q;
  logic [9:0]       frame_q;
  logic             accept;

  assign tx_ready_o = !busy_q;
  assign accept     = tx_valid_i && !busy_q;

  // Ones shift in behind the frame, so the line idles high
  assign tx_o = frame_q[0];

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q  <= 1'b0;
      baud_q  <= '0;
      bit_q   <= '0;
      frame_q <= '1;
    end else if (accept) begin
      // Stop, data LSB first, start
      frame_q <= {1'b1, tx_data_i, 1'b0};
      busy_q  <= 1'b1;
      baud_q  <= BIT_LAST;
      bit_q   <= '0;
    end else if (busy_q) begin
      if (baud_q != '0) begin
        baud_q <= baud_q - 1'b1;
      end else begin
        baud_q  <= BIT_LAST;
        frame_q <= {1'b1, frame_q[9:1]};
        bit_q   <= bit_q + 1'b1;
        // End of stop bit
        if (bit_q == 4'd9) begin
          busy_q <= 1'b0;
        end
      end
    end
  end

endmodule

// File: debug/debug_cmd_fsm.sv
`timescale 1ns/1ps

module debug_cmd_fsm import uart_debug_pkg::*; (
  input  logic      clk,
  input  logic      arst_n_i,
  input  logic      rx_valid_i,
  input  byte_t     rx_data_i,
  input  logic      tx_ready_i,
  output logic      tx_valid_o,
  output byte_t     tx_data_o,
  debug_mem_if.ctrl mem
);

  localparam int unsigned          HDR_CNT_W = $clog2(HDR_BYTES);
  localparam logic [HDR_CNT_W-1:0] HDR_LAST  = HDR_CNT_W'(HDR_BYTES - 1);

  dbg_state_e           state_q;
  logic [HDR_CNT_W-1:0] hdr_q;
  logic [HDR_CNT_W+2:0] hdr_shift;
  logic                 is_read_q;
  logic                 chal_q;
  mem_addr_t            addr_q;
  len_t                 cnt_q;
  logic                 wr_q;
  byte_t                wdata_q;

  // Bit offset of the current header byte
  assign hdr_shift = {hdr_q, 3'b000};

  //////////////////////////////
  // Response bytes
  //////////////////////////////

  // One byte in flight at most
  assign tx_valid_o = tx_ready_i &&
                      (state_q == ST_ACK || state_q == ST_EOT || state_q == ST_RD_SEND);

  always_comb begin
    case (state_q)
      ST_ACK:  tx_data_o = CODE_ACK;
      ST_EOT:  tx_data_o = CODE_EOT;
      default: tx_data_o = mem.rdata;
    endcase
  end

  //////////////////////////////
  // Memory port
  //////////////////////////////

  assign mem.req   = (state_q == ST_RD_REQ) || wr_q;
  assign mem.we    = wr_q;
  assign mem.addr  = addr_q;
  assign mem.wdata = wdata_q;

  // Write data lands one cycle after its byte
  always_ff @(posedge clk) begin
    if (rx_valid_i) begin
      wdata_q <= rx_data_i;
    end
  end

  //////////////////////////////
  // Protocol FSM
  //////////////////////////////

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= ST_IDLE;
      hdr_q     <= '0;
      is_read_q <= 1'b0;
      chal_q    <= 1'b0;
      addr_q    <= '0;
      cnt_q     <= '0;
      wr_q      <= 1'b0;
    end else begin
      wr_q <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (rx_valid_i) begin
            if (rx_data_i == CMD_READ || rx_data_i == CMD_WRITE) begin
              is_read_q <= (rx_data_i == CMD_READ);
              chal_q    <= 1'b0;
              hdr_q     <= '0;
              addr_q    <= '0;
              cnt_q     <= '0;
              state_q   <= ST_ADDR;
            end else if (rx_data_i == CODE_ACK) begin
              // Challenge, echo ACK only
              chal_q  <= 1'b1;
              state_q <= ST_ACK;
            end
          end
        end
        ST_ADDR: begin
          if (rx_valid_i) begin
            // High bytes shift out of range
            addr_q <= addr_q | (mem_addr_t'(rx_data_i) << hdr_shift);
            hdr_q  <= hdr_q + 1'b1;
            if (hdr_q == HDR_LAST) begin
              hdr_q   <= '0;
              state_q <= ST_LEN;
            end
          end
        end
        ST_LEN: begin
          if (rx_valid_i) begin
            cnt_q <= cnt_q | (len_t'(rx_data_i) << hdr_shift);
            hdr_q <= hdr_q + 1'b1;
            if (hdr_q == HDR_LAST) begin
              hdr_q   <= '0;
              state_q <= ST_ACK;
            end
          end
        end
        ST_ACK: begin
          if (tx_valid_o) begin
            if (chal_q) begin
              state_q <= ST_IDLE;
            end else if (cnt_q == '0) begin
              state_q <= ST_EOT;
            end else if (is_read_q) begin
              state_q <= ST_RD_REQ;
            end else begin
              state_q <= ST_WR_DATA;
            end
          end
        end
        ST_RD_REQ: begin
          // rdata is registered at this edge
          addr_q  <= addr_q + 1'b1;
          cnt_q   <= cnt_q - 1'b1;
          state_q <= ST_RD_SEND;
        end
        ST_RD_SEND: begin
          if (tx_valid_o) begin
            state_q <= (cnt_q == '0) ? ST_EOT : ST_RD_REQ;
          end
        end
        ST_WR_DATA: begin
          if (rx_valid_i) begin
            wr_q <= 1'b1;
          end
          if (wr_q) begin
            addr_q <= addr_q + 1'b1;
            cnt_q  <= cnt_q - 1'b1;
            if (cnt_q == len_t'(1)) begin
              state_q <= ST_EOT;
            end
          end
        end
        ST_EOT: begin
          if (tx_valid_o) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

endmodule

// File: debug/debug_mem.sv
`timescale 1ns/1ps

module debug_mem import uart_debug_pkg::*; (
  input  logic     clk,
  debug_mem_if.mem mem
);

  localparam int unsigned DEPTH = 2 ** MEM_ADDR_W;

  byte_t ram_q [DEPTH];
  byte_t rdata_q;

  // Synchronous read, held until the next read
  always_ff @(posedge clk) begin
    if (mem.req) begin
      if (mem.we) begin
        ram_q[mem.addr] <= mem.wdata;
      end else begin
        rdata_q <= ram_q[mem.addr];
      end
    end
  end

  assign mem.rdata = rdata_q;

endmodule

// File: verilog/uart_debug_top.sv
`timescale 1ns/1ps

module uart_debug_top import uart_debug_pkg::*; #(
  parameter int unsigned CLKS_PER_BIT = 8
) (
  input  logic clk,
  input  logic arst_n_i,
  input  logic uart_rx_i,
  output logic uart_tx_o
);

  logic  rx_valid;
  byte_t rx_data;
  logic  tx_valid;
  byte_t tx_data;
  logic  tx_ready;

  debug_mem_if mem_bus ();

  //////////////////////////////
  // Serial in
  //////////////////////////////

  uart_rx #(
    .CLKS_PER_BIT ( CLKS_PER_BIT )
  ) uart_rx_inst (
    .clk        ( clk       ),
    .arst_n_i   ( arst_n_i  ),
    .rx_i       ( uart_rx_i ),
    .rx_valid_o ( rx_valid  ),
    .rx_data_o  ( rx_data   )
  );

  // Command parser and memory
  debug_cmd_fsm debug_cmd_fsm_inst (
    .clk        ( clk      ),
    .arst_n_i   ( arst_n_i ),
    .rx_valid_i ( rx_valid ),
    .rx_data_i  ( rx_data  ),
    .tx_ready_i ( tx_ready ),
    .tx_valid_o ( tx_valid ),
    .tx_data_o  ( tx_data  ),
    .mem        ( mem_bus  )
  );

  debug_mem debug_mem_inst (
    .clk ( clk     ),
    .mem ( mem_bus )
  );

  //////////////////////////////
  // Serial out
  //////////////////////////////

  uart_tx #(
    .CLKS_PER_BIT ( CLKS_PER_BIT )
  ) uart_tx_inst (
    .clk        ( clk       ),
    .arst_n_i   ( arst_n_i  ),
    .tx_valid_i ( tx_valid  ),
    .tx_data_i  ( tx_data   ),
    .tx_ready_o ( tx_ready  ),
    .tx_o       ( uart_tx_o )
  );

endmodule

// File: tb/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int unsigned PERIOD_NS    = 40,
  parameter int unsigned RESET_CYCLES = 5
) (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #(PERIOD_NS / 2);
      clk_o = ~clk_o;
    end
  end

  // Reset released just after a rising edge
  initial begin
    arst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #2;
    arst_n_o = 1'b1;
  end

endmodule

// File: tb/uart_debug_tb.sv
`timescale 1ns/1ps

module uart_debug_tb import uart_debug_pkg::*; ();

  localparam int unsigned CLKS_PER_BIT = 8;

  logic        clk;
  logic        arst_n;
  logic        uart_rx;
  logic        uart_tx;
  logic [31:0] lfsr_q;
  logic        waiting;
  int          errors;
  int          cycles;
  int          limit;
  byte_t       reply_q [$];
  byte_t       trace_data [$];
  logic [7:0]  trace_kind [$];

  tb_clk_gen #(
    .PERIOD_NS    ( 40 ),
    .RESET_CYCLES ( 5  )
  ) tb_clk_gen_inst (
    .clk_o    ( clk    ),
    .arst_n_o ( arst_n )
  );

  uart_debug_top #(
    .CLKS_PER_BIT ( CLKS_PER_BIT )
  ) uart_debug_top_inst (
    .clk       ( clk     ),
    .arst_n_i  ( arst_n  ),
    .uart_rx_i ( uart_rx ),
    .uart_tx_o ( uart_tx )
  );

  //////////////////////////////
  // Host side helpers
  //////////////////////////////

  // Galois LFSR, right shifting
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h80200003;
    end
    return s >> 1;
  endfunction

  task automatic random_bits(input int n, output int value);
    value = 0;
    for (int i = 0; i < n; i++) begin
      value  = (value << 1) | lfsr_q[0];
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  // Idle gap of 0 to 3 bit times, then one 8N1 frame
  task automatic send_byte(input byte_t b);
    logic [9:0] frame;
    int         gap;
    frame = {1'b1, b, 1'b0};
    random_bits(2, gap);
    repeat (gap * CLKS_PER_BIT + 1) @(posedge clk);
    #2;
    for (int i = 0; i < 10; i++) begin
      uart_rx = frame[i];
      repeat (CLKS_PER_BIT) @(posedge clk);
      #2;
    end
  endtask

  task automatic expect_byte(input byte_t exp);
    byte_t got;
    waiting = 1'b1;
    while (reply_q.size() == 0) @(negedge clk);
    waiting = 1'b0;
    got = reply_q.pop_front();
    if (got !== exp) begin
      errors++;
      $display("error at %0t ns: uart_tx_o got %02h, expected %02h", $time, got, exp);
    end
  endtask

  //////////////////////////////
  // Serial monitor
  //////////////////////////////

  initial begin : serial_monitor
    byte_t data;
    wait (arst_n === 1'b1);
    forever begin
      @(negedge uart_tx);
      repeat (CLKS_PER_BIT / 2) @(negedge clk);
      if (uart_tx !== 1'b0) begin
        errors++;
        $display("start bit on uart_tx_o did not stay low at %0t ns", $time);
      end
      for (int i = 0; i < 8; i++) begin
        repeat (CLKS_PER_BIT) @(negedge clk);
        data[i] = uart_tx;
      end
      repeat (CLKS_PER_BIT) @(negedge clk);
      if (uart_tx !== 1'b1) begin
        errors++;
        $display("stop bit of a reply frame on uart_tx_o was low at %0t ns", $time);
      end
      reply_q.push_back(data);
    end
  end

  // Cycle limit scales with the trace length
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= limit) begin
      errors++;
      if (waiting) begin
        $display("timeout, a reply byte on uart_tx_o is still missing");
      end else begin
        $display("timeout, the trace did not finish in time");
      end
      $display("errors: %0d", errors);
      $display("test failed");
      $finish;
    end
  end

  //////////////////////////////
  // Trace runner
  //////////////////////////////

  initial begin : trace_runner
    int         fd;
    int         n;
    logic [7:0] kind;
    logic [7:0] value;
    string      line;
    uart_rx = 1'b1;
    lfsr_q  = 32'hdf0d02b4;
    waiting = 1'b0;
    errors  = 0;
    cycles  = 0;
    fd = $fopen("tb/uart_debug_trace.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("cannot open the trace file tb/uart_debug_trace.txt");
    end else begin
      while (!$feof(fd)) begin
        n = $fscanf(fd, " %c", kind);
        if (n == 1) begin
          if (kind == "#") begin
            n = $fgets(line, fd);
          end else begin
            n = $fscanf(fd, " %h", value);
            if (n == 1) begin
              trace_kind.push_back(kind);
              trace_data.push_back(value);
            end
          end
        end
      end
      $fclose(fd);
    end
    limit = 20 * 10 * CLKS_PER_BIT * trace_kind.size() + 100;

    wait (arst_n === 1'b1);
    foreach (trace_kind[i]) begin
      if (trace_kind[i] == "S") begin
        send_byte(trace_data[i]);
      end else if (trace_kind[i] == "E") begin
        expect_byte(trace_data[i]);
      end else begin
        errors++;
        $display("trace entry %0d has an unknown kind %c", i, trace_kind[i]);
      end
    end

    // Quiet line afterwards, no stray replies
    repeat (20 * CLKS_PER_BIT) @(posedge clk);
    if (reply_q.size() != 0) begin
      errors++;
      $display("%0d reply bytes on uart_tx_o were not expected", reply_q.size());
    end
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: tb/uart_debug_trace.txt
# Pairs of kind and hex byte, read in order, several to a line
# S is a byte the host sends, E is the byte the server must send next
S 06 E 06
S 12 S 10 S 00 S 00 S 00 S 00 S 00 S 00 S 00 S 04 S 00 S 00 S 00 S 00 S 00 S 00 S 00
E 06 S a1 S b2 S c3 S d4 E 04
S 11 S 10 S 00 S 00 S 00 S 00 S 00 S 00 S 00 S 04 S 00 S 00 S 00 S 00 S 00 S 00 S 00
E 06 E a1 E b2 E c3 E d4 E 04
S 12 S ff S 00 S 00 S 00 S 00 S 00 S 00 S 00 S 03 S 00 S 00 S 00 S 00 S 00 S 00 S 00
E 06 S 5c S 6d S 7e E 04
S 11 S ff S 00 S 00 S 00 S 00 S 00 S 00 S 00 S 03 S 00 S 00 S 00 S 00 S 00 S 00 S 00
E 06 E 5c E 6d E 7e E 04
S 11 S 10 S 00 S 00 S 00 S 00 S 00 S 00 S 00 S 00 S 00 S 00 S 00 S 00 S 00 S 00 S 00
E 06 E 04
S 55 S 06 E 06
S 11 S 10 S 5a S 00 S 00 S 00 S 00 S 00 S 77 S 02 S 00 S 00 S 00 S 00 S 00 S 00 S 00
E 06 E a1 E b2 E 04

// File: src.f
common/uart_debug_pkg.sv
common/debug_mem_if.sv
uart/uart_rx.sv
uart/uart_tx.sv
debug/debug_cmd_fsm.sv
debug/debug_mem.sv
verilog/uart_debug_top.sv
tb/tb_clk_gen.sv
tb/uart_debug_tb.sv

// File: Bender.yml
package:
  name: uart_debug

sources:
  - common/uart_debug_pkg.sv
  - common/debug_mem_if.sv
  - uart/uart_rx.sv
  - uart/uart_tx.sv
  - debug/debug_cmd_fsm.sv
  - debug/debug_mem.sv
  - verilog/uart_debug_top.sv
  - target: test
    files:
      - tb/tb_clk_gen.sv
      - tb/uart_debug_tb.sv
